/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int LANES = 4;

    // Data memory size in words
    localparam int MEM_WORDS = 256;
    localparam int WORD_IDX_BITS = $clog2(MEM_WORDS);

    // Low two bits give the size, top bit marks an unsigned load
    typedef enum logic [2:0] {
        MEM_BYTE  = 3'b000,
        MEM_HALF  = 3'b001,
        MEM_WORD  = 3'b010,
        MEM_BYTEU = 3'b100,
        MEM_HALFU = 3'b101
    } mem_func;

    // One data word, as byte lanes or as half lanes
    typedef union packed {
        logic [LANES-1:0][7:0] bytes;
        logic [1:0][15:0]      halves;
    } mem_word;

    // Byte lanes touched by an access of this size at this offset
    function automatic logic [LANES-1:0] store_lanes(
        input mem_func    func,
        input logic [1:0] offset
    );
        logic [LANES-1:0] lanes;
        case (func[1:0])
            2'b00:   lanes = 4'b0001;
            2'b01:   lanes = 4'b0011;
            default: lanes = 4'b1111;
        endcase
        return lanes << offset;
    endfunction

    // Moves store data from the low end into its lanes
    function automatic logic [DATA_BITS-1:0] align_store(
        input logic [DATA_BITS-1:0] data,
        input logic [1:0]           offset
    );
        return data << (8 * offset);
    endfunction

endpackage

`default_nettype wire

/* common/sq_pkg.sv */
`default_nettype none

package sq_pkg;

    localparam int SQ_LEN = 8;

    // One spare slot so a full ring differs from an empty one
    localparam int SQ_SLOTS = SQ_LEN + 1;
    localparam int SQ_LAST = SQ_SLOTS - 1;
    localparam int SQ_IDX_BITS = 4;

    // Almost full once fewer free entries than this remain
    localparam int SQ_MARGIN = 1;

    // Next ring index, wrapping after the last slot
    function automatic logic [SQ_IDX_BITS-1:0] sq_next(
        input logic [SQ_IDX_BITS-1:0] idx
    );
        if (idx == SQ_IDX_BITS'(SQ_LAST)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

endpackage

`default_nettype wire

/* store_queue/sq_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_forward (
    input  logic [sq_pkg::SQ_SLOTS-1:0]                         entry_valid,
    input  logic [sq_pkg::SQ_SLOTS-1:0]                         entry_ready,
    input  mem_pkg::mem_func [sq_pkg::SQ_SLOTS-1:0]             entry_func,
    input  logic [sq_pkg::SQ_SLOTS-1:0][mem_pkg::ADDR_BITS-1:0] entry_addr,
    input  logic [sq_pkg::SQ_SLOTS-1:0][mem_pkg::DATA_BITS-1:0] entry_data,
    input  logic [sq_pkg::SQ_IDX_BITS-1:0]                      head,
    input  logic [sq_pkg::SQ_IDX_BITS-1:0]                      load_sq_tail,
    input  logic [mem_pkg::ADDR_BITS-1:0]                       load_addr,
    output logic [mem_pkg::DATA_BITS-1:0]                       fwd_data,
    output logic [mem_pkg::LANES-1:0]                           fwd_lanes
);

    logic [sq_pkg::SQ_IDX_BITS-1:0] idx;
    logic                           searching;
    logic                           same_word;
    logic [mem_pkg::LANES-1:0]      lanes;
    mem_pkg::mem_word               shifted;
    mem_pkg::mem_word               merged;

    // Oldest to youngest, so a later match overwrites earlier bytes
    always_comb begin
        merged    = '0;
        fwd_lanes = '0;
        idx       = head;
        searching = 1'b1;
        same_word = 1'b0;
        lanes     = '0;
        shifted   = '0;

        for (int i = 0; i < sq_pkg::SQ_LEN; i++) begin
            // Stop at the load's tail, everything past it is younger
            if (idx == load_sq_tail) begin
                searching = 1'b0;
            end

            same_word = entry_addr[idx][mem_pkg::ADDR_BITS-1:2]
                        == load_addr[mem_pkg::ADDR_BITS-1:2];

            if (searching && entry_valid[idx] && entry_ready[idx] && same_word) begin
                lanes   = mem_pkg::store_lanes(entry_func[idx], entry_addr[idx][1:0]);
                shifted = mem_pkg::align_store(entry_data[idx], entry_addr[idx][1:0]);
                for (int b = 0; b < mem_pkg::LANES; b++) begin
                    if (lanes[b]) begin
                        merged.bytes[b] = shifted.bytes[b];
                        fwd_lanes[b]    = 1'b1;
                    end
                end
            end

            idx = sq_pkg::sq_next(idx);
        end
    end

    assign fwd_data = merged;

endmodule

`default_nettype wire

/* store_queue/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
    input  logic                              clock,
    input  logic                              reset,
    // Dispatch
    input  logic                              alloc_valid,
    input  mem_pkg::mem_func                  alloc_func,
    output logic [sq_pkg::SQ_IDX_BITS-1:0]    alloc_idx,
    output logic                              almost_full,
    // Store execution
    input  logic                              exec_valid,
    input  logic [sq_pkg::SQ_IDX_BITS-1:0]    exec_idx,
    input  logic [mem_pkg::ADDR_BITS-1:0]     exec_base,
    input  logic [11:0]                       exec_offset,
    input  logic [mem_pkg::DATA_BITS-1:0]     exec_data,
    // Reorder buffer
    input  logic                              commit_valid,
    // Data memory write port
    output logic                              mem_wr_valid,
    output logic [mem_pkg::ADDR_BITS-1:0]     mem_wr_addr,
    output logic [mem_pkg::DATA_BITS-1:0]     mem_wr_data,
    output logic [mem_pkg::LANES-1:0]         mem_wr_lanes,
    input  logic                              mem_wr_accept,
    // Load search
    input  logic                              load_valid,
    input  logic [mem_pkg::ADDR_BITS-1:0]     load_addr,
    input  mem_pkg::mem_func                  load_func,
    input  logic [sq_pkg::SQ_IDX_BITS-1:0]    load_sq_tail,
    output logic [mem_pkg::DATA_BITS-1:0]     fwd_data,
    output logic [mem_pkg::LANES-1:0]         fwd_lanes,
    // Ring pointers
    output logic [sq_pkg::SQ_IDX_BITS-1:0]    head,
    output logic [sq_pkg::SQ_IDX_BITS-1:0]    tail
);

    // Entry ring
    logic [sq_pkg::SQ_SLOTS-1:0]                            entry_valid;
    logic [sq_pkg::SQ_SLOTS-1:0]                            entry_ready;
    mem_pkg::mem_func [sq_pkg::SQ_SLOTS-1:0]                entry_func;
    logic [sq_pkg::SQ_SLOTS-1:0][mem_pkg::ADDR_BITS-1:0]    entry_addr;
    logic [sq_pkg::SQ_SLOTS-1:0][mem_pkg::DATA_BITS-1:0]    entry_data;

    // Execution stage register
    logic                           exec_valid_q;
    logic [sq_pkg::SQ_IDX_BITS-1:0] exec_idx_q;
    logic [mem_pkg::ADDR_BITS-1:0]  exec_addr_q;
    logic [mem_pkg::DATA_BITS-1:0]  exec_data_q;

    logic [sq_pkg::SQ_IDX_BITS-1:0] used;
    logic [sq_pkg::SQ_IDX_BITS-1:0] commit_count;
    logic                           alloc_fire;
    logic                           drain_fire;

    logic [mem_pkg::DATA_BITS-1:0]  fwd_word_c;
    logic [mem_pkg::LANES-1:0]      fwd_lanes_c;

    assign almost_full = used > sq_pkg::SQ_IDX_BITS'(sq_pkg::SQ_LEN - sq_pkg::SQ_MARGIN);
    assign alloc_fire  = alloc_valid && !almost_full;
    assign alloc_idx   = tail;

    // Drain the oldest store once committed and executed
    assign mem_wr_valid = (commit_count != '0) && entry_valid[head] && entry_ready[head];
    assign mem_wr_addr  = {entry_addr[head][mem_pkg::ADDR_BITS-1:2], 2'b00};
    assign mem_wr_data  = mem_pkg::align_store(entry_data[head], entry_addr[head][1:0]);
    assign mem_wr_lanes = mem_pkg::store_lanes(entry_func[head], entry_addr[head][1:0]);
    assign drain_fire   = mem_wr_valid && mem_wr_accept;

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            used         <= '0;
            commit_count <= '0;
            entry_valid  <= '0;
            entry_ready  <= '0;
            exec_valid_q <= 1'b0;
        end else begin
            exec_valid_q <= exec_valid;

            if (alloc_fire) begin
                entry_valid[tail] <= 1'b1;
                entry_ready[tail] <= 1'b0;
                tail              <= sq_pkg::sq_next(tail);
            end

            // Address and data land one cycle after execution
            if (exec_valid_q) begin
                entry_ready[exec_idx_q] <= 1'b1;
            end

            if (drain_fire) begin
                entry_valid[head] <= 1'b0;
                entry_ready[head] <= 1'b0;
                head              <= sq_pkg::sq_next(head);
            end

            case ({alloc_fire, drain_fire})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase

            // Committed stores still waiting for the memory port
            case ({commit_valid, drain_fire})
                2'b10:   commit_count <= commit_count + 1'b1;
                2'b01:   commit_count <= commit_count - 1'b1;
                default: commit_count <= commit_count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        exec_idx_q  <= exec_idx;
        exec_addr_q <= exec_base + {{(mem_pkg::ADDR_BITS-12){1'b0}}, exec_offset};
        exec_data_q <= exec_data;

        if (alloc_fire) begin
            entry_func[tail] <= alloc_func;
        end
        if (exec_valid_q) begin
            entry_addr[exec_idx_q] <= exec_addr_q;
            entry_data[exec_idx_q] <= exec_data_q;
        end

        // Held so that it lines up with the memory read
        if (load_valid) begin
            fwd_data  <= fwd_word_c;
            fwd_lanes <= fwd_lanes_c & mem_pkg::store_lanes(load_func, load_addr[1:0]);
        end
    end

    sq_forward sq_forward_i (
        .entry_valid  (entry_valid),
        .entry_ready  (entry_ready),
        .entry_func   (entry_func),
        .entry_addr   (entry_addr),
        .entry_data   (entry_data),
        .head         (head),
        .load_sq_tail (load_sq_tail),
        .load_addr    (load_addr),
        .fwd_data     (fwd_word_c),
        .fwd_lanes    (fwd_lanes_c)
    );

endmodule

`default_nettype wire

/* source/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  logic                          clock,
    input  logic                          reset,
    // Store drain port
    input  logic                          wr_valid,
    input  logic [mem_pkg::ADDR_BITS-1:0] wr_addr,
    input  logic [mem_pkg::DATA_BITS-1:0] wr_data,
    input  logic [mem_pkg::LANES-1:0]     wr_lanes,
    output logic                          wr_accept,
    // Load port
    input  logic                          rd_valid,
    input  logic [mem_pkg::ADDR_BITS-1:0] rd_addr,
    output logic [mem_pkg::DATA_BITS-1:0] rd_data
);

    mem_pkg::mem_word mem [0:mem_pkg::MEM_WORDS-1];
    mem_pkg::mem_word wr_word;

    logic [mem_pkg::WORD_IDX_BITS-1:0] wr_index;
    logic [mem_pkg::WORD_IDX_BITS-1:0] rd_index;

    assign wr_word  = wr_data;
    assign wr_index = wr_addr[mem_pkg::WORD_IDX_BITS+1:2];
    assign rd_index = rd_addr[mem_pkg::WORD_IDX_BITS+1:2];

    // Single port, a load takes it first
    assign wr_accept = !rd_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < mem_pkg::MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_valid && wr_accept) begin
            for (int b = 0; b < mem_pkg::LANES; b++) begin
                if (wr_lanes[b]) begin
                    mem[wr_index].bytes[b] <= wr_word.bytes[b];
                end
            end
        end
    end

    // Word is valid the cycle after the request
    always_ff @(posedge clock) begin
        if (rd_valid) begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* source/load_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module load_merge (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          load_valid,
    input  logic [mem_pkg::ADDR_BITS-1:0] load_addr,
    input  mem_pkg::mem_func              load_func,
    input  logic [mem_pkg::DATA_BITS-1:0] fwd_data,
    input  logic [mem_pkg::LANES-1:0]     fwd_lanes,
    input  logic [mem_pkg::DATA_BITS-1:0] mem_data,
    output logic                          load_done,
    output logic [mem_pkg::DATA_BITS-1:0] load_data
);

    logic             done_q;
    logic [1:0]       offset_q;
    mem_pkg::mem_func func_q;

    mem_pkg::mem_word fwd_word;
    mem_pkg::mem_word mem_word_in;
    mem_pkg::mem_word merged;
    logic [7:0]       sel_byte;
    logic [15:0]      sel_half;
    logic             sign_fill;

    assign fwd_word    = fwd_data;
    assign mem_word_in = mem_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= load_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (load_valid) begin
            offset_q <= load_addr[1:0];
            func_q   <= load_func;
        end
    end

    always_comb begin
        // Forwarded bytes take precedence over memory
        for (int b = 0; b < mem_pkg::LANES; b++) begin
            merged.bytes[b] = fwd_lanes[b] ? fwd_word.bytes[b] : mem_word_in.bytes[b];
        end

        sel_byte = merged.bytes[offset_q];
        sel_half = merged.halves[offset_q[1]];

        case (func_q[1:0])
            2'b00: begin
                sign_fill = sel_byte[7] && !func_q[2];
                load_data = {{(mem_pkg::DATA_BITS-8){sign_fill}}, sel_byte};
            end
            2'b01: begin
                sign_fill = sel_half[15] && !func_q[2];
                load_data = {{(mem_pkg::DATA_BITS-16){sign_fill}}, sel_half};
            end
            default: begin
                sign_fill = 1'b0;
                load_data = merged;
            end
        endcase
    end

    assign load_done = done_q;

endmodule

`default_nettype wire

/* source/lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           alloc_valid,
    input  mem_pkg::mem_func               alloc_func,
    output logic [sq_pkg::SQ_IDX_BITS-1:0] alloc_idx,
    output logic                           almost_full,
    input  logic                           exec_valid,
    input  logic [sq_pkg::SQ_IDX_BITS-1:0] exec_idx,
    input  logic [mem_pkg::ADDR_BITS-1:0]  exec_base,
    input  logic [11:0]                    exec_offset,
    input  logic [mem_pkg::DATA_BITS-1:0]  exec_data,
    input  logic                           commit_valid,
    input  logic                           load_valid,
    input  logic [mem_pkg::ADDR_BITS-1:0]  load_addr,
    input  mem_pkg::mem_func               load_func,
    input  logic [sq_pkg::SQ_IDX_BITS-1:0] load_sq_tail,
    output logic                           load_done,
    output logic [mem_pkg::DATA_BITS-1:0]  load_data,
    output logic [sq_pkg::SQ_IDX_BITS-1:0] head,
    output logic [sq_pkg::SQ_IDX_BITS-1:0] tail
);

    // Store drain to memory
    logic                          mem_wr_valid;
    logic [mem_pkg::ADDR_BITS-1:0] mem_wr_addr;
    logic [mem_pkg::DATA_BITS-1:0] mem_wr_data;
    logic [mem_pkg::LANES-1:0]     mem_wr_lanes;
    logic                          mem_wr_accept;

    // The two load paths
    logic [mem_pkg::DATA_BITS-1:0] fwd_data;
    logic [mem_pkg::LANES-1:0]     fwd_lanes;
    logic [mem_pkg::DATA_BITS-1:0] mem_data;

    store_queue store_queue_i (
        .clock         (clock),
        .reset         (reset),
        .alloc_valid   (alloc_valid),
        .alloc_func    (alloc_func),
        .alloc_idx     (alloc_idx),
        .almost_full   (almost_full),
        .exec_valid    (exec_valid),
        .exec_idx      (exec_idx),
        .exec_base     (exec_base),
        .exec_offset   (exec_offset),
        .exec_data     (exec_data),
        .commit_valid  (commit_valid),
        .mem_wr_valid  (mem_wr_valid),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_wr_lanes  (mem_wr_lanes),
        .mem_wr_accept (mem_wr_accept),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_func     (load_func),
        .load_sq_tail  (load_sq_tail),
        .fwd_data      (fwd_data),
        .fwd_lanes     (fwd_lanes),
        .head          (head),
        .tail          (tail)
    );

    data_memory data_memory_i (
        .clock     (clock),
        .reset     (reset),
        .wr_valid  (mem_wr_valid),
        .wr_addr   (mem_wr_addr),
        .wr_data   (mem_wr_data),
        .wr_lanes  (mem_wr_lanes),
        .wr_accept (mem_wr_accept),
        .rd_valid  (load_valid),
        .rd_addr   (load_addr),
        .rd_data   (mem_data)
    );

    load_merge load_merge_i (
        .clock      (clock),
        .reset      (reset),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_func  (load_func),
        .fwd_data   (fwd_data),
        .fwd_lanes  (fwd_lanes),
        .mem_data   (mem_data),
        .load_done  (load_done),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

/* dv/lsq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_tb;

    localparam int MAX_OPS = 128;
    localparam int MAX_STORES = 64;
    localparam int SLOTS = sq_pkg::SQ_LEN + 1;
    localparam int OP_IDLE = 0;
    localparam int OP_ALLOC = 1;
    localparam int OP_EXEC = 2;
    localparam int OP_COMMIT = 3;
    localparam int OP_LOAD = 4;

    logic                           clock;
    logic                           reset;
    logic                           alloc_valid;
    mem_pkg::mem_func               alloc_func;
    logic [sq_pkg::SQ_IDX_BITS-1:0] alloc_idx;
    logic                           almost_full;
    logic                           exec_valid;
    logic [sq_pkg::SQ_IDX_BITS-1:0] exec_idx;
    logic [31:0]                    exec_base;
    logic [11:0]                    exec_offset;
    logic [31:0]                    exec_data;
    logic                           commit_valid;
    logic                           load_valid;
    logic [31:0]                    load_addr;
    mem_pkg::mem_func               load_func;
    logic [sq_pkg::SQ_IDX_BITS-1:0] load_sq_tail;
    logic                           load_done;
    logic [31:0]                    load_data;
    logic [sq_pkg::SQ_IDX_BITS-1:0] head;
    logic [sq_pkg::SQ_IDX_BITS-1:0] tail;

    // Operations from the trace
    int          op_code [MAX_OPS];
    logic [31:0] op_arg [MAX_OPS][4];
    int          op_count;

    // Reference model, every allocated store in program order
    logic [2:0]  st_func [MAX_STORES];
    logic [3:0]  st_idx [MAX_STORES];
    logic [31:0] st_addr [MAX_STORES];
    logic [31:0] st_data [MAX_STORES];
    bit          st_exec [MAX_STORES];
    int          st_count = 0;
    int          ref_tail = 0;
    int          commits = 0;

    int cycle_count = 0;
    int cycle_limit = 200;

    lsq_top lsq_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("FAILED at %0t: %s", $time, msg));
    endtask

    function automatic int access_size(input logic [2:0] func);
        case (func[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    // Replays the stores older than the load tail over a zeroed memory
    function automatic logic [31:0] expected_load(
        input logic [31:0] addr,
        input logic [2:0]  func,
        input int          sq_tail
    );
        logic [7:0]  lane_byte [4];
        logic [31:0] value;
        int          older;
        int          size;
        older = st_count - (ref_tail + SLOTS - sq_tail) % SLOTS;
        for (int b = 0; b < 4; b++) begin
            lane_byte[b] = 8'h00;
        end
        for (int s = 0; s < older; s++) begin
            if (st_exec[s] && st_addr[s][31:2] == addr[31:2]) begin
                size = access_size(st_func[s]);
                for (int k = 0; k < size; k++) begin
                    lane_byte[st_addr[s][1:0] + k] = st_data[s][8*k +: 8];
                end
            end
        end
        size = access_size(func);
        value = '0;
        for (int k = 0; k < size; k++) begin
            value[8*k +: 8] = lane_byte[addr[1:0] + k];
        end
        if (!func[2] && size < 4 && value[8*size-1]) begin
            value = value | (32'hffff_ffff << (8 * size));
        end
        return value;
    endfunction

    // One load with every store older, checked one cycle later
    task automatic check_load(input logic [31:0] addr, input logic [2:0] func);
        logic [31:0] expected;
        expected = expected_load(addr, func, ref_tail);
        @(posedge clock);
        load_valid <= 1'b1;
        load_addr <= addr;
        load_func <= mem_pkg::mem_func'(func);
        load_sq_tail <= sq_pkg::SQ_IDX_BITS'(ref_tail);
        @(posedge clock);
        load_valid <= 1'b0;
        @(negedge clock);
        assert (load_done && load_data == expected)
            else report_mismatch($sformatf("load %h func %0d gave %h, expected %h",
                                           addr, func, load_data, expected));
    endtask

    task automatic read_trace();
        int                fd;
        int                got;
        logic [8*8-1:0]    word;
        logic [8*128-1:0]  rest;
        fd = $fopen("dv/lsq_trace.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open the trace file dv/lsq_trace.txt");
        end
        op_count = 0;
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word == "#") begin
                got = $fgets(rest, fd);
            end else begin
                case (word)
                    "alloc":  op_code[op_count] = OP_ALLOC;
                    "exec":   op_code[op_count] = OP_EXEC;
                    "commit": op_code[op_count] = OP_COMMIT;
                    "load":   op_code[op_count] = OP_LOAD;
                    "idle":   op_code[op_count] = OP_IDLE;
                    default:  stop_run($sformatf("Unknown operation %0s in the trace", word));
                endcase
                if (op_code[op_count] == OP_ALLOC) begin
                    got = $fscanf(fd, "%h %h", op_arg[op_count][0], op_arg[op_count][1]);
                    if (got != 2) begin
                        stop_run($sformatf("Trace operation %0d has missing fields", op_count));
                    end
                end else if (op_code[op_count] == OP_EXEC || op_code[op_count] == OP_LOAD) begin
                    got = $fscanf(fd, "%h %h %h %h", op_arg[op_count][0], op_arg[op_count][1],
                                  op_arg[op_count][2], op_arg[op_count][3]);
                    if (got != 4) begin
                        stop_run($sformatf("Trace operation %0d has missing fields", op_count));
                    end
                end
                op_count++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic        pending_load;
        logic [31:0] pending_value;
        logic [31:0] cur_value;
        int          found;
        reset = 1'b1;
        alloc_valid = 1'b0;
        alloc_func = mem_pkg::MEM_WORD;
        exec_valid = 1'b0;
        exec_idx = '0;
        exec_base = '0;
        exec_offset = '0;
        exec_data = '0;
        commit_valid = 1'b0;
        load_valid = 1'b0;
        load_addr = '0;
        load_func = mem_pkg::MEM_WORD;
        load_sq_tail = '0;
        pending_load = 1'b0;
        pending_value = '0;
        cur_value = '0;
        read_trace();
        cycle_limit = 10 * op_count + 200;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        for (int n = 0; n <= op_count; n++) begin
            @(posedge clock);
            alloc_valid <= 1'b0;
            exec_valid <= 1'b0;
            commit_valid <= 1'b0;
            load_valid <= 1'b0;
            if (n < op_count) begin
                case (op_code[n])
                    OP_ALLOC: begin
                        alloc_valid <= 1'b1;
                        alloc_func <= mem_pkg::mem_func'(op_arg[n][0][2:0]);
                    end
                    OP_EXEC: begin
                        exec_valid <= 1'b1;
                        exec_idx <= op_arg[n][0][3:0];
                        exec_base <= op_arg[n][1];
                        exec_offset <= op_arg[n][2][11:0];
                        exec_data <= op_arg[n][3];
                    end
                    OP_COMMIT: commit_valid <= 1'b1;
                    OP_LOAD: begin
                        load_valid <= 1'b1;
                        load_addr <= op_arg[n][0];
                        load_func <= mem_pkg::mem_func'(op_arg[n][1][2:0]);
                        load_sq_tail <= op_arg[n][2][3:0];
                        cur_value = expected_load(op_arg[n][0], op_arg[n][1][2:0], op_arg[n][2]);
                        assert (cur_value == op_arg[n][3])
                            else report_mismatch($sformatf("trace line %0d expects %h, model gives %h",
                                                           n, op_arg[n][3], cur_value));
                    end
                    default: ;
                endcase
            end

            @(negedge clock);
            if (pending_load) begin
                assert (load_done && load_data == pending_value)
                    else report_mismatch($sformatf("load done %b data %h, expected %h",
                                                   load_done, load_data, pending_value));
            end else begin
                assert (!load_done) else report_mismatch("load_done without a load");
            end
            // A full ring of uncommitted stores must report almost full
            if (st_count - commits >= sq_pkg::SQ_LEN) begin
                assert (almost_full) else report_mismatch("almost_full low with a full queue");
            end
            pending_load = (n < op_count) && (op_code[n] == OP_LOAD);
            pending_value = cur_value;
            if (n == op_count) begin
                break;
            end

            case (op_code[n])
                OP_ALLOC: begin
                    assert (!almost_full && alloc_idx == op_arg[n][1] && alloc_idx == ref_tail)
                        else report_mismatch($sformatf("alloc index %0d, expected %0d",
                                                       alloc_idx, op_arg[n][1]));
                    st_func[st_count] = op_arg[n][0][2:0];
                    st_idx[st_count] = ref_tail;
                    st_exec[st_count] = 1'b0;
                    st_count++;
                    ref_tail = (ref_tail + 1) % SLOTS;
                end
                OP_EXEC: begin
                    found = -1;
                    for (int s = st_count - 1; s >= 0; s--) begin
                        if (found < 0 && !st_exec[s] && st_idx[s] == op_arg[n][0][3:0]) begin
                            found = s;
                        end
                    end
                    if (found < 0) begin
                        stop_run("The trace executes a store that was never allocated");
                    end
                    st_addr[found] = op_arg[n][1] + {20'h0, op_arg[n][2][11:0]};
                    st_data[found] = op_arg[n][3];
                    st_exec[found] = 1'b1;
                end
                OP_COMMIT: commits++;
                default: ;
            endcase
        end

        // Committed stores keep draining until the ring is empty
        while (head != tail) begin
            @(negedge clock);
        end
        assert (tail == sq_pkg::SQ_IDX_BITS'(ref_tail))
            else report_mismatch($sformatf("queue drained at index %0d, expected %0d",
                                           tail, ref_tail));
        assert (!almost_full) else report_mismatch("almost_full high on an empty queue");

        // Every size and extension at each lane offset of the stored words
        for (int w = 1; w <= 3; w++) begin
            for (int off = 0; off < 4; off++) begin
                check_load(32'h100 * w + off, 3'b000);
                check_load(32'h100 * w + off, 3'b100);
                if (off % 2 == 0) begin
                    check_load(32'h100 * w + off, 3'b001);
                    check_load(32'h100 * w + off, 3'b101);
                end
                if (off == 0) begin
                    check_load(32'h100 * w + off, 3'b010);
                end
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/lsq_trace.txt */
# alloc func idx | exec idx base offset data | commit | idle
# load addr func sq_tail expected (all values hex)
alloc 2 0
alloc 2 1
alloc 1 2
alloc 0 3
exec 0 00000100 000 11223344
exec 1 00000100 004 a5b6c7d8
exec 2 00000100 002 00008899
exec 3 00000100 001 000000f0
alloc 2 4
load 00000100 2 4 8899f044
load 00000101 0 4 fffffff0
load 00000102 5 4 00008899
load 00000103 0 4 ffffff88
load 00000106 1 4 ffffa5b6
load 00000100 2 3 88993344
load 00000100 2 0 00000000
alloc 0 5
alloc 4 6
alloc 2 7
exec 4 00000200 000 cafebabe
exec 5 00000200 003 0000007e
exec 6 00000200 001 00000081
exec 7 00000300 000 01020304
commit
load 00000200 2 8 7efe81be
load 00000201 0 6 ffffffba
load 00000100 2 8 8899f044
idle
load 00000100 2 8 8899f044
alloc 2 8
exec 8 00000100 000 deadbeef
commit
commit
commit
load 00000100 2 0 deadbeef
load 00000101 0 8 fffffff0
alloc 1 0
exec 0 00000300 002 0000ff11
idle
load 00000300 2 1 ff110304
load 00000300 1 0 00000304
commit
commit
commit
commit
commit
commit
idle
load 00000203 0 1 0000007e
load 00000302 5 1 0000ff11

/* filelist.f */
common/mem_pkg.sv
common/sq_pkg.sv
store_queue/sq_forward.sv
store_queue/store_queue.sv
source/data_memory.sv
source/load_merge.sv
source/lsq_top.sv
dv/lsq_tb.sv
